//--- design/mem_pkg.sv
package mem_pkg;

	// plain widths with a meaning
	typedef logic [31:0] word_t;    // one data word
	typedef logic [31:0] addr_t;    // byte address
	typedef logic [4:0]  reg_sel_t; // destination register index
	typedef logic [3:0]  wmask_t;   // one enable per byte lane

	// access size as coded in funct3[1:0]
	typedef enum logic [1:0] {
		size_byte = 2'b00,
		size_half = 2'b01,
		size_word = 2'b10
	} access_size_e;

	// request from access unit to cache and from cache to memory
	typedef struct packed {
		logic   valid; // one cycle pulse
		logic   rw;    // 1 means write
		addr_t  addr;  // always word aligned
		wmask_t wmask; // byte lanes to write
		word_t  data;  // store data already in its lane
	} mem_req_t;

	// answer to a request
	typedef struct packed {
		logic  ready; // one cycle pulse
		word_t data;  // whole read word
	} mem_resp_t;

	// cache miss and write sequencer
	typedef enum logic [1:0] {
		st_idle,     // waiting for a cpu request
		st_lookup,   // tag compare on the latched request
		st_mem_wait, // backing memory busy
		st_respond   // ready pulse back to the cpu
	} cache_state_e;

	// size from funct3; bit 2 only selects unsigned loads
	function automatic access_size_e decode_size(input logic [2:0] funct3);
		case (funct3[1:0])
			2'b00:   return size_byte;
			2'b01:   return size_half;
			default: return size_word; // 2'b11 is not a legal rv32 size
		endcase
	endfunction

endpackage

//--- design/main_memory.sv
`timescale 1ns/1ps

module main_memory #(
	parameter int MEM_WORDS   = 256, // power of two
	parameter int MEM_LATENCY = 3    // at least 1
) (
	input  logic               clk,
	input  logic               rst,
	input  mem_pkg::mem_req_t  mem_req,
	output mem_pkg::mem_resp_t mem_resp
);
	import mem_pkg::*;

	localparam int AW    = $clog2(MEM_WORDS);
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	typedef logic [CNT_W-1:0] cnt_t;

	word_t    mem_q [MEM_WORDS];
	mem_req_t req_q;   // request kept while counting
	mem_req_t op;      // request being served this cycle
	cnt_t     cnt_q;   // cycles still to go
	cnt_t     cnt_now;
	logic     busy_q;
	logic     fire;    // access happens at the end of this cycle
	logic     ready_q;
	word_t    rdata_q;
	logic [AW-1:0] widx;

	// contents start at zero
	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem_q[i] = '0;
	end

	assign op      = mem_req.valid ? mem_req : req_q;       // a fresh request is served directly
	assign cnt_now = mem_req.valid ? cnt_t'(MEM_LATENCY) : cnt_q;
	assign fire    = (mem_req.valid || busy_q) && (cnt_now == cnt_t'(1));
	assign widx    = op.addr[AW+1:2];

	// latency counter
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy_q  <= 1'b0;
			cnt_q   <= '0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= fire; // single pulse
			if (fire) begin
				busy_q <= 1'b0;
			end else if (mem_req.valid || busy_q) begin
				busy_q <= 1'b1;
				cnt_q  <= cnt_now - 1'b1;
			end
		end
	end

	// storage
	always @(posedge clk) begin
		if (mem_req.valid)
			req_q <= mem_req;
		if (fire) begin
			rdata_q <= mem_q[widx];
			if (op.rw) begin
				for (int b = 0; b < 4; b++) begin
					if (op.wmask[b])
						mem_q[widx][8*b +: 8] <= op.data[8*b +: 8]; // masked lanes only
				end
			end
		end
	end

	assign mem_resp = '{ready: ready_q, data: rdata_q};

	// the cache waits for ready before asking again
	a_no_overlap: assert property (
		@(posedge clk) disable iff (rst)
		mem_req.valid |-> !busy_q
	) else $error("memory request while busy");

endmodule

//--- design/dcache_dm.sv
`timescale 1ns/1ps

module dcache_dm #(
	parameter int CACHE_LINES = 16 // power of two, at least 2
) (
	input  logic               clk,
	input  logic               rst,
	input  mem_pkg::mem_req_t  cpu_req,
	input  mem_pkg::mem_resp_t mem_resp,
	output mem_pkg::mem_resp_t cpu_resp,
	output mem_pkg::mem_req_t  mem_req
);
	import mem_pkg::*;

	localparam int IDX_W = $clog2(CACHE_LINES);
	localparam int TAG_W = 30 - IDX_W; // word address bits above the index

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [TAG_W-1:0] tag_t;

	cache_state_e           state_q;
	mem_req_t               req_q;       // latched cpu request
	word_t                  data_q [CACHE_LINES];
	tag_t                   tag_q  [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid_q;
	word_t                  resp_data_q; // last load word, held for the cpu

	idx_t idx;
	tag_t tag;
	logic hit;
	logic read_hit;
	logic write_hit;
	logic fill;

	// split the latched word address
	assign idx = req_q.addr[IDX_W+1:2];
	assign tag = req_q.addr[31:IDX_W+2];

	assign hit       = valid_q[idx] && (tag_q[idx] == tag);
	assign read_hit  = (state_q == st_lookup) && hit && !req_q.rw;
	assign write_hit = (state_q == st_lookup) && hit && req_q.rw;
	assign fill      = (state_q == st_mem_wait) && mem_resp.ready && !req_q.rw; // read miss returns

	// sequencer
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: begin
					if (cpu_req.valid)
						state_q <= st_lookup;
				end
				st_lookup: begin
					if (read_hit)
						state_q <= st_idle;     // answered in this cycle
					else
						state_q <= st_mem_wait; // miss or write goes to memory
				end
				st_mem_wait: begin
					if (mem_resp.ready)
						state_q <= st_respond;
				end
				st_respond: state_q <= st_idle;
				default:    state_q <= st_idle;
			endcase
		end
	end

	// line valid bits
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			valid_q <= '0;
		else if (fill)
			valid_q[idx] <= 1'b1;
	end

	// request latch, line data and tags
	always_ff @(posedge clk) begin
		if (state_q == st_idle && cpu_req.valid)
			req_q <= cpu_req;
		if (fill) begin
			data_q[idx] <= mem_resp.data; // install fetched word
			tag_q[idx]  <= tag;
		end else if (write_hit) begin
			for (int b = 0; b < 4; b++) begin
				if (req_q.wmask[b])
					data_q[idx][8*b +: 8] <= req_q.data[8*b +: 8]; // merge under mask
			end
		end
		if (read_hit)
			resp_data_q <= data_q[idx];
		else if (fill)
			resp_data_q <= mem_resp.data;
	end

	// responses
	always_comb begin
		cpu_resp.ready = read_hit || (state_q == st_respond);
		cpu_resp.data  = read_hit ? data_q[idx] : resp_data_q; // hit data straight from the array
	end

	always_comb begin
		mem_req.valid = (state_q == st_lookup) && !read_hit; // write through, or fetch on read miss
		mem_req.rw    = req_q.rw;
		mem_req.addr  = req_q.addr;
		mem_req.wmask = req_q.wmask;
		mem_req.data  = req_q.data;
	end

	// one access in flight, so a new request only finds the cache idle
	a_req_when_idle: assert property (
		@(posedge clk) disable iff (rst)
		cpu_req.valid |-> state_q == st_idle
	) else $error("cpu request while cache busy");

	// memory answers only what this cache asked for
	a_ready_in_wait: assert property (
		@(posedge clk) disable iff (rst)
		mem_resp.ready |-> state_q == st_mem_wait
	) else $error("memory ready outside mem_wait");

endmodule

//--- design/mem_access_unit.sv
`timescale 1ns/1ps

module mem_access_unit (
	input  logic                clk,
	input  logic                rst,
	input  logic                mem_load_store, // instruction uses memory
	input  logic                is_store,
	input  logic [2:0]          funct3,
	input  mem_pkg::word_t      rs1,
	input  mem_pkg::word_t      rs2,
	input  logic [23:0]         imm,
	input  mem_pkg::word_t      rd_data_in,
	input  mem_pkg::reg_sel_t   rd_sel_in,
	input  logic                instr_valid,    // one cycle after the pipeline registers latch
	input  mem_pkg::mem_resp_t  cpu_resp,
	output mem_pkg::word_t      rd_data_out,
	output mem_pkg::reg_sel_t   rd_sel_out,
	output logic                stage_complete,
	output mem_pkg::mem_req_t   cpu_req
);
	import mem_pkg::*;

	addr_t        addr;      // effective byte address
	access_size_e size;
	logic [1:0]   lane;      // byte offset inside the word
	logic [4:0]   lane_bits; // same offset in bits
	logic         is_unsigned;
	wmask_t       base_mask; // mask before moving into the lane
	word_t        lane_data; // returned word moved down to bit 0
	word_t        load_data; // extended load result
	logic         done_q;

	assign addr        = rs1 + {{8{imm[23]}}, imm}; // imm sign extended to 32 bits
	assign size        = decode_size(funct3);
	assign is_unsigned = funct3[2];
	assign lane        = addr[1:0];
	assign lane_bits   = {lane, 3'b000};

	// store side
	always_comb begin
		case (size)
			size_byte: base_mask = 4'b0001;
			size_half: base_mask = 4'b0011;
			default:   base_mask = 4'b1111;
		endcase
	end

	always_comb begin
		cpu_req.valid = instr_valid && mem_load_store; // one pulse per memory instruction
		cpu_req.rw    = is_store;
		cpu_req.addr  = {addr[31:2], 2'b00};           // cache works on whole words
		cpu_req.wmask = base_mask << lane;
		cpu_req.data  = rs2 << lane_bits;               // low bytes of rs2 into their lane
	end

	// load side
	assign lane_data = cpu_resp.data >> lane_bits;

	always_comb begin
		case (size)
			size_byte: begin
				if (is_unsigned)
					load_data = {24'b0, lane_data[7:0]};
				else
					load_data = {{24{lane_data[7]}}, lane_data[7:0]};
			end
			size_half: begin
				if (is_unsigned)
					load_data = {16'b0, lane_data[15:0]};
				else
					load_data = {{16{lane_data[15]}}, lane_data[15:0]};
			end
			default: load_data = lane_data;
		endcase
	end

	// completion stays up from the ready pulse until the next instruction
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			done_q <= 1'b1; // stage is free after reset
		else
			done_q <= stage_complete;
	end

	assign stage_complete = !mem_load_store      // non-memory finishes at once
		|| cpu_resp.ready
		|| (done_q && !instr_valid);

	// only a load changes the result, everything else passes through
	assign rd_data_out = (mem_load_store && !is_store) ? load_data : rd_data_in;
	assign rd_sel_out  = rd_sel_in;

	// natural alignment is required, there is no misaligned trap
	property p_aligned;
		@(posedge clk) disable iff (rst)
		(instr_valid && mem_load_store) |->
			((size == size_byte) ||
			 (size == size_half && !addr[0]) ||
			 (size == size_word && addr[1:0] == 2'b00));
	endproperty
	a_aligned: assert property (p_aligned)
		else $error("misaligned access at %h", addr);

endmodule

//--- design/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top #(
	parameter int CACHE_LINES = 16,
	parameter int MEM_WORDS   = 256,
	parameter int MEM_LATENCY = 3
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              mem_load_store,
	input  logic              is_store,
	input  logic [2:0]        funct3,
	input  mem_pkg::word_t    rs1,
	input  mem_pkg::word_t    rs2,
	input  logic [23:0]       imm,
	input  mem_pkg::word_t    rd_data_in,
	input  mem_pkg::reg_sel_t rd_sel_in,
	input  logic              instr_valid,
	output mem_pkg::word_t    rd_data_out,
	output mem_pkg::reg_sel_t rd_sel_out,
	output logic              stage_complete
);
	import mem_pkg::*;

	mem_req_t  cpu_req;  // access unit to cache
	mem_resp_t cpu_resp;
	mem_req_t  mem_req;  // cache to backing memory
	mem_resp_t mem_resp;

	// address, lanes and load extension
	mem_access_unit u_access (
		.clk, .rst,
		.mem_load_store, .is_store, .funct3,
		.rs1, .rs2, .imm,
		.rd_data_in, .rd_sel_in, .instr_valid,
		.cpu_resp,
		.rd_data_out, .rd_sel_out, .stage_complete,
		.cpu_req
	);

	dcache_dm #(.CACHE_LINES(CACHE_LINES)) u_cache (
		.clk, .rst,
		.cpu_req, .mem_resp,
		.cpu_resp, .mem_req
	);

	main_memory #(
		.MEM_WORDS  (MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) u_mem (
		.clk, .rst,
		.mem_req, .mem_resp
	);

endmodule

//--- verif/mem_checker.sv
`timescale 1ns/1ps

module mem_checker #(
	parameter int MEM_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              mem_load_store,
	input  logic              is_store,
	input  logic [2:0]        funct3,
	input  mem_pkg::word_t    rs1,
	input  mem_pkg::word_t    rs2,
	input  logic [23:0]       imm,
	input  mem_pkg::word_t    rd_data_in,
	input  mem_pkg::reg_sel_t rd_sel_in,
	input  logic              instr_valid,
	input  mem_pkg::word_t    rd_data_out,
	input  mem_pkg::reg_sel_t rd_sel_out,
	input  logic              stage_complete,
	output int                errors,
	output int                checks
);
	import mem_pkg::*;

	localparam int BYTES = MEM_WORDS * 4;

	logic [7:0] model [BYTES]; // byte image of the backing memory
	logic       pending;       // memory access still open
	logic       after_reset;   // first idle cycle after reset not yet checked
	word_t      exp_data;
	reg_sel_t   exp_sel;
	int         base;          // byte index of the access

	initial begin
		for (int i = 0; i < BYTES; i++)
			model[i] = 8'h00; // memory starts at zero
		errors      = 0;
		checks      = 0;
		pending     = 1'b0;
		after_reset = 1'b0;
	end

	task automatic compare(input string name, input word_t exp, input word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error: %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	// little endian bytes, extended by size and funct3[2]
	function automatic word_t predict_load(input int b, input logic [2:0] f3);
		word_t v;
		case (f3[1:0])
			2'b00: v = f3[2] ? {24'h0, model[b]} : {{24{model[b][7]}}, model[b]};
			2'b01: begin
				v = {16'h0, model[b+1], model[b]};
				if (!f3[2])
					v[31:16] = {16{model[b+1][7]}}; // sign from the upper byte
			end
			default: v = {model[b+3], model[b+2], model[b+1], model[b]};
		endcase
		return v;
	endfunction

	task automatic apply_store(input int b, input logic [1:0] sz, input word_t d);
		int n;
		n = (sz == 2'b00) ? 1 : (sz == 2'b01) ? 2 : 4;
		for (int k = 0; k < n; k++)
			model[b+k] = d[8*k +: 8]; // low bytes of rs2, other lanes untouched
	endtask

	// sampled mid cycle, away from the clock edge and the 2 ns input change
	always @(negedge clk) begin
		if (rst) begin
			pending     = 1'b0;
			after_reset = 1'b1;
		end else begin
			if (after_reset) begin
				compare("stage_complete", 32'h1, {31'b0, stage_complete}); // idle after reset
				after_reset = 1'b0;
			end
			if (pending && stage_complete) begin // access finished
				compare("rd_data_out", exp_data, rd_data_out);
				compare("rd_sel_out", word_t'(exp_sel), word_t'(rd_sel_out));
				pending = 1'b0;
			end
			if (instr_valid) begin
				if (pending) begin
					errors++;
					$display("new instruction issued before the previous access completed");
				end
				base     = int'((rs1 + {{8{imm[23]}}, imm}) % BYTES);
				exp_sel  = rd_sel_in;
				exp_data = rd_data_in; // stores and non-memory pass through
				if (!mem_load_store) begin
					compare("stage_complete", 32'h1, {31'b0, stage_complete}); // same cycle
					compare("rd_data_out", rd_data_in, rd_data_out);
					compare("rd_sel_out", word_t'(rd_sel_in), word_t'(rd_sel_out));
				end else begin
					if (is_store)
						apply_store(base, funct3[1:0], rs2);
					else
						exp_data = predict_load(base, funct3);
					pending = 1'b1;
				end
			end
		end
	end

endmodule

//--- verif/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
	import mem_pkg::*;

	localparam int CACHE_LINES  = 16;
	localparam int MEM_WORDS    = 256;
	localparam int MEM_LATENCY  = 3;
	localparam int N_INSTR      = 400;
	localparam int WINDOW_WORDS = 48; // three tags share each cache index
	localparam int CLK_PERIOD   = 40;
	localparam int TIMEOUT_NS   = (N_INSTR * (MEM_LATENCY + 4) + 50) * CLK_PERIOD;

	logic     clk;
	logic     rst;
	logic     mem_load_store;
	logic     is_store;
	logic [2:0] funct3;
	word_t    rs1;
	word_t    rs2;
	logic [23:0] imm;
	word_t    rd_data_in;
	reg_sel_t rd_sel_in;
	logic     instr_valid;
	word_t    rd_data_out;
	reg_sel_t rd_sel_out;
	logic     stage_complete;
	int       err_count;
	int       check_count;
	integer   seed;

	always #(CLK_PERIOD / 2) clk = ~clk;

	mem_stage_top #(
		.CACHE_LINES(CACHE_LINES),
		.MEM_WORDS  (MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) u_dut (
		.clk, .rst,
		.mem_load_store, .is_store, .funct3,
		.rs1, .rs2, .imm,
		.rd_data_in, .rd_sel_in, .instr_valid,
		.rd_data_out, .rd_sel_out, .stage_complete
	);

	mem_checker #(.MEM_WORDS(MEM_WORDS)) u_check (
		.clk, .rst,
		.mem_load_store, .is_store, .funct3,
		.rs1, .rs2, .imm,
		.rd_data_in, .rd_sel_in, .instr_valid,
		.rd_data_out, .rd_sel_out, .stage_complete,
		.errors(err_count),
		.checks(check_count)
	);

	// one random instruction with a one cycle valid pulse
	task automatic send_instr();
		integer      r;
		int          word_idx;
		logic [1:0]  size;
		logic [1:0]  offset;
		logic [23:0] off;
		addr_t       target;
		@(posedge clk);
		#2;
		r              = $random(seed);
		mem_load_store = (r[1:0] != 2'b00);                  // a quarter pass straight through
		is_store       = r[2];
		size           = (r[4:3] == 2'b11) ? 2'b10 : r[4:3]; // word twice as often
		funct3         = {!is_store && r[5] && size != 2'b10, size};
		word_idx       = $unsigned($random(seed)) % WINDOW_WORDS;
		r              = $random(seed);
		case (size)
			2'b00:   offset = r[1:0];
			2'b01:   offset = {r[1], 1'b0};
			default: offset = 2'b00;
		endcase
		target      = addr_t'(word_idx * 4) + addr_t'(offset); // naturally aligned
		off         = {{12{r[13]}}, r[13:2]};                   // small signed offset
		imm         = off;
		rs1         = target - {{8{off[23]}}, off};
		rs2         = $random(seed);
		rd_data_in  = $random(seed);
		rd_sel_in   = r[20:16];
		instr_valid = 1'b1;
		@(posedge clk);
		#2;
		instr_valid = 1'b0;
	endtask

	task automatic wait_for_complete();
		@(negedge clk);
		while (!stage_complete)
			@(negedge clk);
	endtask

	initial begin
		seed           = 69;
		clk            = 1'b0;
		rst            = 1'b1;
		mem_load_store = 1'b1; // completion after reset then comes from the stage state
		is_store       = 1'b0;
		funct3         = 3'b000;
		rs1            = '0;
		rs2            = '0;
		imm            = '0;
		rd_data_in     = '0;
		rd_sel_in      = '0;
		instr_valid    = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < N_INSTR; i++) begin
			send_instr();
			wait_for_complete();
		end
		repeat (4) @(posedge clk);
		$display("checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0 && check_count > 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// sized for the slowest access on every instruction
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: stage_complete did not rise after an instruction");
		$display("checks %0d, errors %0d", check_count, err_count);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- files.f
design/mem_pkg.sv
design/main_memory.sv
design/dcache_dm.sv
design/mem_access_unit.sv
design/mem_stage_top.sv
verif/mem_checker.sv
verif/tb_mem_stage.sv
